//--- Makefile
# Verilator build and run of the oversampling CDR testbench

VERILATOR ?= verilator
TOP       ?= tb_oversampling_cdr
FLIST     ?= oversampling_cdr.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
HDRS := $(wildcard verilog/*.svh)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# The run passes only if the log holds the pass line
run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_oversampling_cdr.sv
`default_nettype none
`timescale 1ns/1ns

`include "cdr_settings.svh"

// Directed testbench for the oversampling CDR. Builds sample words from
// source bits, drives one word per clock and checks the recovered bits
module tb_oversampling_cdr;

	////////////////////////////////////////////////////////////////////////////
	// Bench constants and signals

	// Half of the 200 ns clock period
	localparam int HALF_PERIOD = 100;
	// Inputs change this long after the rising edge
	localparam int STIM_DELAY = 10;
	localparam int RESET_CYCLES = 16;
	// Words between the input of the edge finder and rx
	localparam int LATENCY = 6;
	// Bound on the wait for a steady output
	localparam int SETTLE_LIMIT = 24;
	// Bound on the whole run
	localparam int RUN_LIMIT = 2000;

	logic                     clk_312p5mhz;
	logic                     rst;
	logic [`CDR_SAMPLE_W-1:0] rx_samples;
	cdr_pkg::cdr_rx_t         rx;

	// State of the stimulus LFSR
	logic [15:0] lfsr;

	int checks;
	int errors;
	// Error count when the current test started
	int test_errors;

	// Source bits of a stream test and the words built from them
	logic                     src_bits[$];
	logic [`CDR_SAMPLE_W-1:0] line_words[$];
	// Entry c is rx as seen just before word c was driven
	cdr_pkg::cdr_rx_t         rx_seen[$];
	// Recovered bits, oldest first
	logic                     out_bits[$];

	oversampling_cdr i_oversampling_cdr (
		.clk_312p5mhz (clk_312p5mhz),
		.rst          (rst),
		.rx_samples   (rx_samples),
		.rx           (rx)
	);

	initial clk_312p5mhz = 1'b0;

	always #HALF_PERIOD clk_312p5mhz = ~clk_312p5mhz;

	// Stops a run that hangs
	initial begin
		repeat (RUN_LIMIT) @(posedge clk_312p5mhz);
		$display("Run stopped after %0d cycles before all tests finished", RUN_LIMIT);
		$display("** FAIL **");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	// Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	// One LFSR step for every bit taken
	task automatic take_random_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b = lfsr[0];
	endtask

	function automatic cdr_pkg::cdr_rx_t make_rx(input logic [`CDR_DATA_W-1:0] data,
		input logic [`CDR_COUNT_W-1:0] count);
		cdr_pkg::cdr_rx_t r;
		r.data = data;
		r.count = count;
		return r;
	endfunction

	// Each source bit becomes k equal samples, packed 16 to a word with the
	// first sample in the MSB
	task automatic build_line(input int k);
		logic [`CDR_SAMPLE_W-1:0] word;
		int fill;
		line_words.delete();
		word = '0;
		fill = 0;
		foreach (src_bits[n]) begin
			for (int r = 0; r < k; r++) begin
				word = {word[`CDR_SAMPLE_W-2:0], src_bits[n]};
				fill++;
				if (fill == `CDR_SAMPLE_W) begin
					line_words.push_back(word);
					fill = 0;
				end
			end
		end
	endtask

	// Waits one clock, records rx and presents the next word
	task automatic drive_word(input logic [`CDR_SAMPLE_W-1:0] word);
		@(posedge clk_312p5mhz);
		#STIM_DELAY;
		rx_seen.push_back(rx);
		rx_samples = word;
	endtask

	// Sends the whole line, then repeats its last word until the last real
	// word has left the pipeline
	task automatic run_line();
		rx_seen.delete();
		foreach (line_words[w])
			drive_word(line_words[w]);
		repeat (LATENCY) drive_word(line_words[line_words.size()-1]);
	endtask

	// Valid bits sit at data[count-1] down to data[0], oldest first
	task automatic unpack_rx(input cdr_pkg::cdr_rx_t r);
		for (int i = int'(r.count) - 1; i >= 0; i--) begin
			if (i < `CDR_DATA_W)
				out_bits.push_back(r.data[i]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks and report

	task automatic compare_rx(input string name, input cdr_pkg::cdr_rx_t expected,
		input cdr_pkg::cdr_rx_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %s expected data=%b count=%0d actual data=%b count=%0d",
				name, expected.data, expected.count, actual.data, actual.count);
		end
	endtask

	task automatic compare_count(input string name, input logic [`CDR_COUNT_W-1:0] expected,
		input logic [`CDR_COUNT_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %s expected count=%0d actual count=%0d", name, expected, actual);
		end
	endtask

	// A window boundary may cut one bit, so totals may differ by one
	task automatic compare_total(input string name, input int expected, input int actual);
		checks++;
		if ((actual < expected - 1) || (actual > expected + 1)) begin
			errors++;
			$display("ERR %s expected %0d bits (+/- 1) actual %0d bits",
				name, expected, actual);
		end
	endtask

	task automatic report_failure(input string name, input string what);
		checks++;
		errors++;
		$display("%s: %s", name, what);
	endtask

	// Recovered bit i against source bit offset+i
	task automatic compare_stream(input string name, input int offset);
		foreach (out_bits[i]) begin
			if (offset + i >= src_bits.size()) begin
				report_failure(name, "more bits were recovered than were sent");
				break;
			end
			checks++;
			if (out_bits[i] !== src_bits[offset+i]) begin
				errors++;
				$display("ERR %s bit %0d expected %b actual %b",
					name, i, src_bits[offset+i], out_bits[i]);
			end
		end
	endtask

	task automatic end_test(input string name);
		$display("Test %s finished with %0d errors", name, errors - test_errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	// Every stage is cleared during reset, and zero records keep leaving
	// the pipeline until the first word arrives six clocks later
	task automatic test_reset();
		string name = "reset";
		test_errors = errors;
		rst = 1'b1;
		rx_samples = '0;
		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(posedge clk_312p5mhz);
			#STIM_DELAY;
			compare_count(name, '0, rx.count);
		end
		rst = 1'b0;
		for (int c = 0; c < LATENCY; c++) begin
			compare_count(name, '0, rx.count);
			@(posedge clk_312p5mhz);
			#STIM_DELAY;
		end
		end_test(name);
	endtask

	// Repeats one word until rx shows the expected record, then checks that
	// the record holds for eight more words
	task automatic hold_pattern(input string name, input logic [`CDR_SAMPLE_W-1:0] word,
		input cdr_pkg::cdr_rx_t expected);
		int waited;
		test_errors = errors;
		waited = 0;
		rx_seen.delete();
		drive_word(word);
		while ((rx_seen[$] !== expected) && (waited < SETTLE_LIMIT)) begin
			drive_word(word);
			waited++;
		end
		if (rx_seen[$] !== expected) begin
			report_failure(name, "output did not reach its steady value in time");
		end else begin
			repeat (8) begin
				drive_word(word);
				compare_rx(name, expected, rx_seen[$]);
			end
		end
		end_test(name);
	endtask

	// Four samples per bit puts exactly four bits in every word
	task automatic test_random_four();
		string name = "random_4x";
		logic b;
		test_errors = errors;
		src_bits.delete();
		for (int n = 0; n < 64 * 4; n++) begin
			take_random_bit(b);
			src_bits.push_back(b);
		end
		build_line(4);
		run_line();
		out_bits.delete();
		for (int w = 2; w < 64; w++) begin
			compare_count(name, `CDR_COUNT_W'd4, rx_seen[w+LATENCY].count);
			unpack_rx(rx_seen[w+LATENCY]);
		end
		// The settled stream starts with the first bit of word 2
		compare_stream(name, 2 * 4);
		end_test(name);
	endtask

	// Five samples per bit. The slices only track a longer bit period
	// across edges, so every bit differs from the one before it
	task automatic test_five_sample();
		string name = "five_sample";
		int total;
		int expected;
		int first_bit;
		int align;
		logic level;
		test_errors = errors;
		take_random_bit(level);
		src_bits.delete();
		for (int n = 0; n < 80 * `CDR_SAMPLE_W / 5; n++)
			src_bits.push_back(level ^ logic'(n % 2));
		build_line(5);
		run_line();
		out_bits.delete();
		total = 0;
		for (int w = 2; w < 80; w++) begin
			total += int'(rx_seen[w+LATENCY].count);
			unpack_rx(rx_seen[w+LATENCY]);
		end
		// Bits whose centre sample lies in words 2 to 79
		expected = 0;
		first_bit = -1;
		foreach (src_bits[n]) begin
			if ((n * 5 + 2 >= 2 * `CDR_SAMPLE_W) && (n * 5 + 2 < 80 * `CDR_SAMPLE_W)) begin
				expected++;
				if (first_bit < 0)
					first_bit = n;
			end
		end
		compare_total(name, expected, total);
		// Align on the first source bit near the window start that matches
		align = -1;
		for (int j = first_bit - 1; j <= first_bit + 1; j++) begin
			if ((align < 0) && (out_bits.size() > 0) && (src_bits[j] === out_bits[0]))
				align = j;
		end
		if (align < 0)
			report_failure(name, "recovered bits match no source bit near the window start");
		else
			compare_stream(name, align);
		end_test(name);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		rst = 1'b1;
		rx_samples = '0;
		lfsr = 16'd63;
		checks = 0;
		errors = 0;
		test_errors = 0;

		test_reset();
		// With no edges the first sample is 15 and each slice steps by 4
		hold_pattern("idle_zero", 16'h0000, make_rx(5'b00000, 3'd4));
		hold_pattern("idle_one", 16'hffff, make_rx(5'b01111, 3'd4));
		hold_pattern("alternating_4x", 16'hf0f0, make_rx(5'b01010, 3'd4));
		test_random_four();
		test_five_sample();

		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- oversampling_cdr.f
+incdir+verilog
verilog/cdr_pkg.sv
verilog/cdr_phase_select.sv
verilog/cdr_edge_finder.sv
verilog/cdr_bit_slice.sv
verilog/oversampling_cdr.sv
dv/tb_oversampling_cdr.sv

//--- verilog/cdr_bit_slice.sv
`default_nettype none
`timescale 1ns/1ns

`include "cdr_settings.svh"

// One data bit per stage. Takes the sample at the current position and
// moves the position on by about one bit period, tracking the edges
module cdr_bit_slice (
	input  wire                  clk_312p5mhz,
	input  wire                  rst,
	input  wire cdr_pkg::cdr_slice_t slice_in,
	output cdr_pkg::cdr_slice_t  slice_out
);

	// Positions one to four samples later in time, which count downwards
	logic [`CDR_POS_W-1:0] pos_m1;
	logic [`CDR_POS_W-1:0] pos_m2;
	logic [`CDR_POS_W-1:0] pos_m3;
	logic [`CDR_POS_W-1:0] pos_m4;

	// Edges at those positions, only where the position is inside the word
	logic hit_next;
	logic hit_2;
	logic hit_3;
	logic hit_4;

	cdr_pkg::cdr_slice_t slice_next;

	assign pos_m1 = slice_in.start - `CDR_POS_W'd1;
	assign pos_m2 = slice_in.start - `CDR_POS_W'd2;
	assign pos_m3 = slice_in.start - `CDR_POS_W'd3;
	assign pos_m4 = slice_in.start - `CDR_POS_W'd4;

	// At position 0 there is no following sample in this word. This also
	// covers the reset record, since live starts are 11 or higher
	assign hit_next = (slice_in.start == '0) || slice_in.edges[pos_m1];

	assign hit_2 = (slice_in.start >= `CDR_POS_W'd2) && slice_in.edges[pos_m2];
	assign hit_3 = (slice_in.start >= `CDR_POS_W'd3) && slice_in.edges[pos_m3];
	assign hit_4 = (slice_in.start >= `CDR_POS_W'd4) && slice_in.edges[pos_m4];

	always_comb begin
		slice_next = slice_in;

		if (slice_in.done) begin
			// Word used up, later stages only carry the record along
			slice_next = slice_in;
		end else if ((slice_in.count == '0) && hit_next) begin
			// First bit sits right before an edge, leave it to the next word
			slice_next = slice_in;
		end else begin
			slice_next.count = slice_in.count + `CDR_COUNT_W'd1;
			slice_next.data = {slice_in.data[`CDR_DATA_W-2:0], slice_in.samples[slice_in.start]};

			// The next edge is expected two to four samples on
			if (hit_2) begin
				slice_next.start = pos_m2 - `CDR_POS_W'd1;
				slice_next.done = (slice_in.start < `CDR_POS_W'd3);
			end else if (hit_3) begin
				slice_next.start = pos_m4;
				slice_next.done = (slice_in.start < `CDR_POS_W'd4);
			end else if (hit_4) begin
				slice_next.start = pos_m4 - `CDR_POS_W'd1;
				slice_next.done = (slice_in.start < `CDR_POS_W'd5);
			end else begin
				// No edge seen, so assume one nominal bit period
				slice_next.start = pos_m4;
				slice_next.done = (slice_in.start < `CDR_POS_W'd4);
			end
		end
	end

	always_ff @(posedge clk_312p5mhz) begin
		if (rst)
			slice_out <= '0;
		else
			slice_out <= slice_next;
	end

endmodule

`default_nettype wire

//--- verilog/cdr_edge_finder.sv
`default_nettype none
`timescale 1ns/1ns

`include "cdr_settings.svh"

// First pipeline stage. Finds the transitions in each new word, picks the
// first sample position and starts the record for the bit slices
module cdr_edge_finder (
	input  wire                      clk_312p5mhz,
	input  wire                      rst,
	input  wire [`CDR_SAMPLE_W-1:0]  samples,
	output cdr_pkg::cdr_slice_t      slice
);

	// Transition flags of the incoming word
	logic [`CDR_SAMPLE_W-1:0] new_edges;

	// Previous word's edges on top, the incoming word's edges below
	logic [`CDR_EDGE_W-1:0] edge_window;

	// First sample position chosen for the incoming word
	logic [`CDR_POS_W-1:0] start_sel;

	////////////////////////////////////////////////////////////////////////////
	// Transition detection

	// Sample 15 is compared with the last sample of the word before it, so
	// an edge on the word boundary is not lost
	assign new_edges[15] = samples[15] ^ slice.samples[0];
	assign new_edges[14:0] = samples[14:0] ^ samples[15:1];

	// The registered edges already hold the previous word's flags
	assign edge_window = {slice.edges, new_edges};

	cdr_phase_select i_phase_select (
		.edge_window (edge_window),
		.start_old   (slice.start),
		.start       (start_sel)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stage register

	always_ff @(posedge clk_312p5mhz) begin
		if (rst) begin
			slice <= '0;
		end else begin
			slice.samples <= samples;
			slice.edges <= new_edges;
			slice.start <= start_sel;
			// No bits are taken yet
			slice.data <= '0;
			slice.count <= '0;
			slice.done <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/cdr_phase_select.sv
`default_nettype none
`timescale 1ns/1ns

`include "cdr_settings.svh"

// Picks the position of the first sample to take in the current word.
// The window holds the edges of the previous word in the upper half and
// the edges of the current word in the lower half
module cdr_phase_select (
	input  wire  [`CDR_EDGE_W-1:0] edge_window,
	input  wire  [`CDR_POS_W-1:0]  start_old,
	output logic [`CDR_POS_W-1:0]  start
);

	////////////////////////////////////////////////////////////////////////////
	// Boundary cases

	// True when the previous word had no transition at all
	logic quiet_prev;

	// Runs split across the word boundary that the previous word already
	// took in full, so an early edge at 12 or 13 must not add a bit here
	logic skip_12;
	logic skip_13;

	// Cases where the run before the early edge is long enough to round up
	// to a bit of its own, which is then sampled from position 15
	logic round_12;
	logic round_13;

	assign quiet_prev = (edge_window[31:16] == 16'd0);

	// A quiet previous word that began at 12 ended on its sample 0, so this
	// is a 2+3 run and is skipped. The other terms are runs of 14+3, 6+3
	// and 10+3 samples that end just past the boundary
	assign skip_12 = (quiet_prev && (start_old == 4'd12)) ||
		((edge_window[28:15] == 14'd0) && edge_window[29]) ||
		((edge_window[20:15] == 6'd0) && edge_window[21]) ||
		((edge_window[24:15] == 10'd0) && edge_window[25]);

	// A run of 1+3 rounds up to one bit and 3+3 or 4+3 round up to two
	assign round_12 = (edge_window[17:15] == 3'd0) || edge_window[16];

	// With the edge at 13 the split runs are 16+2, 15+2, 14+2, 11+2, 10+2,
	// 7+2 and 6+2, and a quiet previous word that began at 12 or 13 means
	// a long run of about 20 samples that the previous word already took
	assign skip_13 = (quiet_prev && ((start_old == 4'd12) || (start_old == 4'd13))) ||
		((edge_window[30:15] == 16'd0) && edge_window[31]) ||
		((edge_window[29:15] == 15'd0) && edge_window[30]) ||
		((edge_window[28:15] == 14'd0) && edge_window[29]) ||
		((edge_window[25:15] == 11'd0) && edge_window[26]) ||
		((edge_window[24:15] == 10'd0) && edge_window[25]) ||
		((edge_window[21:15] == 7'd0) && edge_window[22]) ||
		((edge_window[20:15] == 6'd0) && edge_window[21]);

	// A run of 1+2 gives one bit and the remaining short runs round up
	assign round_13 = (edge_window[19:14] == 6'd0) || edge_window[16];

	////////////////////////////////////////////////////////////////////////////
	// Edge search

	always_comb begin
		logic       found;
		logic [1:0] edge_phase;

		found = 1'b0;
		edge_phase = 2'd0;
		start = 4'd15;

		// An edge in the first four samples gives the best phase estimate
		for (int i = 15; i >= 12; i--) begin
			if (edge_window[i] && !found) begin
				found = 1'b1;
				start = `CDR_POS_W'(i - 1);

				if ((i == 12) && !skip_12 && round_12)
					start = 4'd15;

				if ((i == 13) && !skip_13 && round_13)
					start = 4'd15;
			end
		end

		if (!found) begin
			// Fall back to the most recent edge of the previous word
			for (int i = 16; i < 31; i++) begin
				if (edge_window[i] && !found) begin
					found = 1'b1;
					edge_phase = 2'(i);
				end
			end

			// Then to the first edge further into this word
			for (int i = 11; i >= 0; i--) begin
				if (edge_window[i] && !found) begin
					found = 1'b1;
					edge_phase = 2'(i);
				end
			end

			// Bit period is about four samples, so only the edge phase
			// matters and the first sample sits one after it.
			// No edge at all leaves phase 0 and so a start of 15
			case (edge_phase)
				2'd0: start = 4'd15;
				2'd1: start = 4'd12;
				2'd2: start = 4'd13;
				2'd3: start = 4'd14;
				default: start = 4'd15;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/cdr_pkg.sv
`default_nettype none

`include "cdr_settings.svh"

package cdr_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Stage to stage record

	// Everything one bit slice needs to take the next bit from a word.
	// The word and its edges travel with it so that each stage sees the
	// same sample word as the stage before it did
	typedef struct packed {
		// The sample word, position 15 is the first sample in time
		logic [`CDR_SAMPLE_W-1:0] samples;
		// Flag at position i marks a change between samples i+1 and i
		logic [`CDR_SAMPLE_W-1:0] edges;
		// Position of the next sample to take
		logic [`CDR_POS_W-1:0]    start;
		// Bits taken so far, newest bit in the LSB
		logic [`CDR_DATA_W-1:0]   data;
		// How many of the data bits are valid
		logic [`CDR_COUNT_W-1:0]  count;
		// Set once start has run off the end of the word
		logic                     done;
	} cdr_slice_t;

	////////////////////////////////////////////////////////////////////////////
	// Output record

	// Recovered bits of one word, the oldest valid bit is data[count-1]
	typedef struct packed {
		logic [`CDR_DATA_W-1:0]  data;
		logic [`CDR_COUNT_W-1:0] count;
	} cdr_rx_t;

endpackage

`default_nettype wire

//--- verilog/cdr_settings.svh
`ifndef CDR_SETTINGS_SVH
`define CDR_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Word and history widths

// One word of line samples per clk_312p5mhz cycle, MSB is the oldest sample
`define CDR_SAMPLE_W 16

// Edge history spans the current word and the one before it
`define CDR_EDGE_W 32

// A sample position indexes one word
`define CDR_POS_W 4

////////////////////////////////////////////////////////////////////////////
// Recovered data

// At about four samples per bit a word holds at most five bit centres
`define CDR_DATA_W 5

// Holds a bit count of 0 to 5
`define CDR_COUNT_W 3

// One slice stage per possible bit in a word
`define CDR_NUM_SLICES 5

`endif

//--- verilog/oversampling_cdr.sv
`default_nettype none
`timescale 1ns/1ns

`include "cdr_settings.svh"

// Data recovery for a serial line oversampled at about four samples per
// bit. Each clk_312p5mhz cycle takes one 16-sample word and returns 0 to 5
// recovered bits, six cycles later
module oversampling_cdr (
	input  wire                     clk_312p5mhz,
	input  wire                     rst,
	input  wire [`CDR_SAMPLE_W-1:0] rx_samples,
	output wire cdr_pkg::cdr_rx_t   rx
);

	////////////////////////////////////////////////////////////////////////////
	// Pipeline records

	// Entry 0 comes from the edge finder, entry g+1 from slice g
	cdr_pkg::cdr_slice_t stage [0:`CDR_NUM_SLICES];

	////////////////////////////////////////////////////////////////////////////
	// Edge detection and first phase

	cdr_edge_finder i_edge_finder (
		.clk_312p5mhz (clk_312p5mhz),
		.rst          (rst),
		.samples      (rx_samples),
		.slice        (stage[0])
	);

	////////////////////////////////////////////////////////////////////////////
	// Bit slices

	// Usually four stages take a bit, the fifth one only when the line
	// runs slightly fast against the local clock
	for (genvar g = 0; g < `CDR_NUM_SLICES; g++) begin : g_slice
		cdr_bit_slice i_bit_slice (
			.clk_312p5mhz (clk_312p5mhz),
			.rst          (rst),
			.slice_in     (stage[g]),
			.slice_out    (stage[g+1])
		);
	end

	// Only the recovered bits leave the block
	assign rx = '{
		data:  stage[`CDR_NUM_SLICES].data,
		count: stage[`CDR_NUM_SLICES].count
	};

endmodule

`default_nettype wire
